/* rtl/exec_pkg.sv */
package exec_pkg;

  localparam int xlen = 32;
  localparam int csr_addr_width = 12;
  localparam int gpr_addr_width = 5;

  // add and srl turn into sub and sra when the modifier bit is set
  typedef enum logic [2:0] {
    alu_add  = 3'd0,
    alu_sll  = 3'd1,
    alu_slt  = 3'd2,
    alu_sltu = 3'd3,
    alu_xor  = 3'd4,
    alu_srl  = 3'd5,
    alu_or   = 3'd6,
    alu_and  = 3'd7
  } alu_op_t;

  // load/store code: bit 3 load, bit 2 sign extend, bits 1:0 size
  typedef logic [3:0] ls_op_t;

  localparam int ls_load_bit = 3;
  localparam int ls_sign_bit = 2;

  localparam logic [1:0] size_byte = 2'd0;
  localparam logic [1:0] size_half = 2'd1;
  localparam logic [1:0] size_word = 2'd2;

  localparam ls_op_t ls_none = 4'b0000;
  localparam ls_op_t ls_lb   = 4'b1100;
  localparam ls_op_t ls_lh   = 4'b1101;
  localparam ls_op_t ls_lw   = 4'b1110;
  localparam ls_op_t ls_lbu  = 4'b1000;
  localparam ls_op_t ls_lhu  = 4'b1001;
  // stores keep bit 2 set so that sb never reads as none
  localparam ls_op_t ls_sb   = 4'b0100;
  localparam ls_op_t ls_sh   = 4'b0101;
  localparam ls_op_t ls_sw   = 4'b0110;

  typedef enum logic [2:0] {
    goto_none      = 3'd0,
    goto_jal       = 3'd1,
    goto_jalr      = 3'd2,
    goto_trap_ret  = 3'd3,
    goto_branch_nz = 3'd4,
    goto_branch_z  = 3'd5
  } goto_op_t;

  typedef enum logic [1:0] {
    csrw_none      = 2'd0,
    csrw_write_alu = 2'd1,
    csrw_write_b   = 2'd2,
    csrw_ebreak    = 2'd3
  } csrw_op_t;

  function automatic logic [2:0] size_bytes(input logic [1:0] size);
    case (size)
      size_byte: return 3'd1;
      size_half: return 3'd2;
      default:   return 3'd4;
    endcase
  endfunction

endpackage

/* rtl/alu.sv */
module alu
  import exec_pkg::*;
(
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  input  alu_op_t         op,
  input  logic            mod,
  output logic [xlen-1:0] result
);

  logic signed [xlen-1:0] a_signed;
  logic signed [xlen-1:0] b_signed;
  logic [4:0]             shamt;

  assign a_signed = a;
  assign b_signed = b;
  // only the low five bits count for RV32 shifts
  assign shamt = b[4:0];

  always_comb begin
    case (op)
      alu_add: begin
        if (mod) begin
          result = a - b;
        end else begin
          result = a + b;
        end
      end
      alu_sll: result = a << shamt;
      alu_slt: result = {{(xlen - 1){1'b0}}, a_signed < b_signed};
      alu_sltu: result = {{(xlen - 1){1'b0}}, a < b};
      alu_xor: result = a ^ b;
      alu_srl: begin
        if (mod) begin
          result = a_signed >>> shamt;
        end else begin
          result = a >> shamt;
        end
      end
      alu_or: result = a | b;
      alu_and: result = a & b;
      default: result = '0;
    endcase
  end

endmodule

/* rtl/branch_unit.sv */
module branch_unit
  import exec_pkg::*;
(
  input  goto_op_t        goto,
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] val_a,
  input  logic [xlen-1:0] val_c,
  input  logic [xlen-1:0] alu_result,
  output logic            jump_en,
  output logic [xlen-1:0] jump_target
);

  logic            result_nz;
  logic [xlen-1:0] base;
  logic [xlen-1:0] offset;
  logic [xlen-1:0] sum;

  assign result_nz = |alu_result;

  always_comb begin
    case (goto)
      goto_none:      jump_en = 1'b0;
      goto_branch_nz: jump_en = result_nz;
      goto_branch_z:  jump_en = ~result_nz;
      default:        jump_en = 1'b1;
    endcase
  end

  // register-relative for jalr and trap return, pc-relative otherwise
  always_comb begin
    case (goto)
      goto_jalr, goto_trap_ret: base = val_a;
      default:                  base = pc;
    endcase
    if (goto == goto_trap_ret) begin
      offset = '0;
    end else begin
      offset = val_c;
    end
  end

  assign sum = base + offset;
  assign jump_target = {sum[xlen-1:1], 1'b0};

endmodule

/* rtl/mem_align.sv */
module mem_align
  import exec_pkg::*;
#(
  parameter int bus_width = 64
) (
  input  logic [xlen-1:0]        addr,
  input  ls_op_t                 ls,
  input  logic [xlen-1:0]        store_value,
  input  logic [bus_width-1:0]   bus_rdata,
  output logic [bus_width-1:0]   w_data,
  output logic [bus_width/8-1:0] w_strb,
  output logic [xlen-1:0]        load_value
);

  localparam int strb_width = bus_width / 8;
  localparam int off_width = $clog2(strb_width);

  logic [off_width-1:0]  offset;
  logic [strb_width-1:0] base_strb;
  logic                  is_store;
  logic [bus_width-1:0]  rdata_shifted;
  logic [xlen-1:0]       lane;
  logic                  sign_fill;

  // byte lane inside the bus word
  assign offset = addr[off_width-1:0];

  assign is_store = (ls != ls_none) && !ls[ls_load_bit];

  assign w_data = bus_width'(store_value) << {offset, 3'b000};

  always_comb begin
    if (is_store) begin
      base_strb = strb_width'((32'd1 << size_bytes(ls[1:0])) - 32'd1);
    end else begin
      base_strb = '0;
    end
  end

  assign w_strb = base_strb << offset;

  assign rdata_shifted = bus_rdata >> {offset, 3'b000};
  assign lane = rdata_shifted[xlen-1:0];

  always_comb begin
    sign_fill = 1'b0;
    case (ls[1:0])
      size_byte: begin
        sign_fill = ls[ls_sign_bit] & lane[7];
        load_value = {{(xlen - 8){sign_fill}}, lane[7:0]};
      end
      size_half: begin
        sign_fill = ls[ls_sign_bit] & lane[15];
        load_value = {{(xlen - 16){sign_fill}}, lane[15:0]};
      end
      default: begin
        load_value = lane;
      end
    endcase
  end

endmodule

/* rtl/exec_control.sv */
module exec_control
  import exec_pkg::*;
#(
  parameter int bus_width = 64
) (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      in_valid,
  output logic                      in_ready,
  input  logic [xlen-1:0]           in_pc,
  input  logic [xlen-1:0]           in_val_a,
  input  logic [xlen-1:0]           in_val_b,
  input  logic [xlen-1:0]           in_val_c,
  input  logic                      in_alu_src,
  input  alu_op_t                   in_alu_op,
  input  logic                      in_alu_mod,
  input  logic [gpr_addr_width-1:0] in_rd,
  input  logic                      in_rd_src,
  input  ls_op_t                    in_ls,
  input  goto_op_t                  in_goto,
  input  csrw_op_t                  in_csrw,
  output logic                      out_valid,
  input  logic                      out_ready,
  output logic [xlen-1:0]           out_pc,
  output logic                      out_gpr_wen,
  output logic [gpr_addr_width-1:0] out_gpr_waddr,
  output logic [xlen-1:0]           out_gpr_wdata,
  output logic                      out_csr_wen,
  output logic [csr_addr_width-1:0] out_csr_waddr,
  output logic [xlen-1:0]           out_csr_wdata,
  output logic                      ar_valid,
  input  logic                      ar_ready,
  output logic [xlen-1:0]           ar_addr,
  output logic [2:0]                ar_size,
  input  logic                      r_valid,
  output logic                      r_ready,
  output logic                      aw_valid,
  input  logic                      aw_ready,
  output logic [xlen-1:0]           aw_addr,
  output logic [2:0]                aw_size,
  output logic                      w_valid,
  input  logic                      w_ready,
  input  logic                      b_valid,
  output logic                      b_ready,
  output logic [xlen-1:0]           alu_a,
  output logic [xlen-1:0]           alu_b,
  output alu_op_t                   alu_op,
  output logic                      alu_mod,
  output ls_op_t                    ls,
  output goto_op_t                  goto,
  output logic [xlen-1:0]           pc,
  output logic [xlen-1:0]           val_a,
  output logic [xlen-1:0]           val_c,
  input  logic [xlen-1:0]           alu_result,
  input  logic [xlen-1:0]           load_value
);

  typedef enum logic [2:0] {
    st_idle, st_hold, st_load_req, st_load_resp,
    st_store_req, st_store_addr, st_store_data, st_store_resp
  } state_t;

  state_t                    state;
  state_t                    state_next;
  logic                      running;
  logic                      accept;
  logic [xlen-1:0]           val_b;
  logic                      alu_src;
  logic [gpr_addr_width-1:0] rd;
  logic                      rd_src;
  csrw_op_t                  csrw;
  logic [xlen-1:0]           load_val;

  if (bus_width != 32 && bus_width != 64) begin : g_width_check
    $error("exec_control: bus_width must be 32 or 64");
  end

  // low through reset, high from the first cycle after it
  assign in_ready = running && (state == st_idle || (state == st_hold && out_ready));
  assign accept = in_valid && in_ready;

  always_comb begin
    state_next = state;
    case (state)
      st_idle, st_hold: begin
        if (accept) begin
          if (in_ls == ls_none) state_next = st_hold;
          else if (in_ls[ls_load_bit]) state_next = st_load_req;
          else state_next = st_store_req;
        end else if (state == st_hold && out_ready) begin
          state_next = st_idle;
        end
      end
      st_load_req: if (ar_ready) state_next = st_load_resp;
      st_load_resp: if (r_valid) state_next = st_hold;
      st_store_req: begin
        // address and data may be taken on different edges
        if (aw_ready && w_ready) state_next = st_store_resp;
        else if (aw_ready) state_next = st_store_data;
        else if (w_ready) state_next = st_store_addr;
      end
      st_store_addr: if (aw_ready) state_next = st_store_resp;
      st_store_data: if (w_ready) state_next = st_store_resp;
      st_store_resp: if (b_valid) state_next = st_hold;
      default: state_next = st_idle;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
      running <= 1'b0;
      rd <= '0;
      ls <= ls_none;
      goto <= goto_none;
      csrw <= csrw_none;
    end else begin
      state <= state_next;
      running <= 1'b1;
      if (accept) begin
        rd <= in_rd;
        ls <= in_ls;
        goto <= in_goto;
        csrw <= in_csrw;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      pc <= in_pc;
      val_a <= in_val_a;
      val_b <= in_val_b;
      val_c <= in_val_c;
      alu_src <= in_alu_src;
      alu_op <= in_alu_op;
      alu_mod <= in_alu_mod;
      rd_src <= in_rd_src;
    end
    if (r_valid && r_ready) begin
      load_val <= load_value;
    end
  end

  assign alu_a = alu_src ? pc : val_a;
  assign alu_b = val_b;

  assign ar_valid = state == st_load_req;
  assign r_ready = state == st_load_resp;
  assign aw_valid = state == st_store_req || state == st_store_addr;
  assign w_valid = state == st_store_req || state == st_store_data;
  assign b_ready = state == st_store_resp;
  assign ar_addr = alu_result;
  assign aw_addr = alu_result;
  assign ar_size = {1'b0, ls[1:0]};
  assign aw_size = {1'b0, ls[1:0]};

  assign out_valid = state == st_hold;
  assign out_pc = pc;
  assign out_gpr_wen = |rd;
  assign out_gpr_waddr = rd;
  assign out_gpr_wdata = ls[ls_load_bit] ? load_val : (rd_src ? val_a : alu_result);

  // ebreak shows up as a write to csr 0
  assign out_csr_wen = csrw != csrw_none;
  assign out_csr_waddr = (csrw == csrw_ebreak) ? '0 : val_c[csr_addr_width-1:0];
  assign out_csr_wdata = (csrw == csrw_write_alu) ? alu_result : val_b;

endmodule

/* rtl/exec_stage.sv */
module exec_stage
  import exec_pkg::*;
#(
  parameter int bus_width = 64
) (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      in_valid,
  output logic                      in_ready,
  input  logic [xlen-1:0]           in_pc,
  input  logic [xlen-1:0]           in_val_a,
  input  logic [xlen-1:0]           in_val_b,
  input  logic [xlen-1:0]           in_val_c,
  input  logic                      in_alu_src,
  input  alu_op_t                   in_alu_op,
  input  logic                      in_alu_mod,
  input  logic [gpr_addr_width-1:0] in_rd,
  input  logic                      in_rd_src,
  input  ls_op_t                    in_ls,
  input  goto_op_t                  in_goto,
  input  csrw_op_t                  in_csrw,
  output logic                      out_valid,
  input  logic                      out_ready,
  output logic [xlen-1:0]           out_pc,
  output logic                      out_gpr_wen,
  output logic [gpr_addr_width-1:0] out_gpr_waddr,
  output logic [xlen-1:0]           out_gpr_wdata,
  output logic                      out_csr_wen,
  output logic [csr_addr_width-1:0] out_csr_waddr,
  output logic [xlen-1:0]           out_csr_wdata,
  output logic                      jump_en,
  output logic [xlen-1:0]           jump_target,
  output logic                      ar_valid,
  input  logic                      ar_ready,
  output logic [xlen-1:0]           ar_addr,
  output logic [2:0]                ar_size,
  input  logic                      r_valid,
  output logic                      r_ready,
  input  logic [bus_width-1:0]      r_data,
  output logic                      aw_valid,
  input  logic                      aw_ready,
  output logic [xlen-1:0]           aw_addr,
  output logic [2:0]                aw_size,
  output logic                      w_valid,
  input  logic                      w_ready,
  output logic [bus_width-1:0]      w_data,
  output logic [bus_width/8-1:0]    w_strb,
  input  logic                      b_valid,
  output logic                      b_ready
);

  logic [xlen-1:0] alu_a;
  logic [xlen-1:0] alu_b;
  alu_op_t         alu_op;
  logic            alu_mod;
  ls_op_t          ls;
  goto_op_t        goto;
  logic [xlen-1:0] pc;
  logic [xlen-1:0] val_a;
  logic [xlen-1:0] val_c;
  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] load_value;

  exec_control #(.bus_width(bus_width)) u_control (.*);

  alu u_alu (.a(alu_a), .b(alu_b), .op(alu_op), .mod(alu_mod), .result(alu_result));

  branch_unit u_branch (
    .goto(goto), .pc(pc), .val_a(val_a), .val_c(val_c), .alu_result(alu_result),
    .jump_en(jump_en), .jump_target(jump_target)
  );

  // store data comes from val_c, address from the alu sum
  mem_align #(.bus_width(bus_width)) u_align (
    .addr(alu_result), .ls(ls), .store_value(val_c), .bus_rdata(r_data),
    .w_data(w_data), .w_strb(w_strb), .load_value(load_value)
  );

endmodule

/* testbench/axi_mem_model.sv */
module axi_mem_model #(
  parameter int bus_width = 64
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   ar_valid,
  output logic                   ar_ready,
  input  logic [31:0]            ar_addr,
  output logic                   r_valid,
  input  logic                   r_ready,
  output logic [bus_width-1:0]   r_data,
  input  logic                   aw_valid,
  output logic                   aw_ready,
  input  logic [31:0]            aw_addr,
  input  logic                   w_valid,
  output logic                   w_ready,
  input  logic [bus_width-1:0]   w_data,
  input  logic [bus_width/8-1:0] w_strb,
  output logic                   b_valid,
  input  logic                   b_ready
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int strb_width = bus_width / 8;

  logic [7:0]            mem [0:255];
  logic [31:0]           seed = 32'd69841;
  logic                  rd_pend, got_aw, got_w, b_pend;
  logic [1:0]            rd_wait, b_wait;
  logic [7:0]            rd_base, wr_base;
  logic [bus_width-1:0]  wr_data;
  logic [strb_width-1:0] wr_strb;

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return {seed[15:0], seed[31:16]};
  endfunction

  initial begin
    ar_ready = 1'b0;
    aw_ready = 1'b0;
    w_ready = 1'b0;
    r_valid = 1'b0;
    b_valid = 1'b0;
    r_data = '0;
  end

  // handshakes and the write commit happen on the rising edge
  always @(posedge clock) begin
    if (reset) begin
      rd_pend <= 1'b0;
      got_aw <= 1'b0;
      got_w <= 1'b0;
      b_pend <= 1'b0;
    end else begin
      if (ar_valid && ar_ready) begin
        rd_pend <= 1'b1;
        rd_base <= ar_addr[7:0] & ~8'(strb_width - 1);
        rd_wait <= next_rand() % 4;
      end else if (rd_pend && rd_wait != 0) begin
        rd_wait <= rd_wait - 1;
      end
      if (r_valid && r_ready) rd_pend <= 1'b0;
      if (aw_valid && aw_ready) begin
        got_aw <= 1'b1;
        wr_base <= aw_addr[7:0] & ~8'(strb_width - 1);
      end
      if (w_valid && w_ready) begin
        got_w <= 1'b1;
        wr_data <= w_data;
        wr_strb <= w_strb;
      end
      if (got_aw && got_w && !b_pend) begin
        for (int k = 0; k < strb_width; k++) begin
          if (wr_strb[k]) mem[8'(wr_base + k)] <= wr_data[8*k +: 8];
        end
        b_pend <= 1'b1;
        b_wait <= next_rand() % 4;
      end else if (b_pend && b_wait != 0) begin
        b_wait <= b_wait - 1;
      end
      if (b_valid && b_ready) begin
        b_pend <= 1'b0;
        got_aw <= 1'b0;
        got_w <= 1'b0;
      end
    end
  end

  always @(negedge clock) begin
    ar_ready = next_rand() % 3 != 0;
    aw_ready = next_rand() % 3 != 0;
    w_ready = next_rand() % 3 != 0;
    r_valid = rd_pend && rd_wait == 0;
    b_valid = b_pend && b_wait == 0;
    for (int k = 0; k < strb_width; k++) r_data[8*k +: 8] = mem[8'(rd_base + k)];
  end

endmodule

/* testbench/exec_stage_checker.sv */
module exec_stage_checker
  import exec_pkg::*;
#(
  parameter int bus_width = 64
) (
  input logic                      clock,
  input logic                      reset,
  input logic                      in_valid,
  input logic                      in_ready,
  input logic [xlen-1:0]           in_pc,
  input logic [xlen-1:0]           in_val_a,
  input logic [xlen-1:0]           in_val_b,
  input logic [xlen-1:0]           in_val_c,
  input logic                      in_alu_src,
  input alu_op_t                   in_alu_op,
  input logic                      in_alu_mod,
  input logic [gpr_addr_width-1:0] in_rd,
  input logic                      in_rd_src,
  input ls_op_t                    in_ls,
  input goto_op_t                  in_goto,
  input csrw_op_t                  in_csrw,
  input logic                      out_valid,
  input logic                      out_ready,
  input logic [xlen-1:0]           out_pc,
  input logic                      out_gpr_wen,
  input logic [gpr_addr_width-1:0] out_gpr_waddr,
  input logic [xlen-1:0]           out_gpr_wdata,
  input logic                      out_csr_wen,
  input logic [csr_addr_width-1:0] out_csr_waddr,
  input logic [xlen-1:0]           out_csr_wdata,
  input logic                      jump_en,
  input logic [xlen-1:0]           jump_target,
  input logic                      ar_valid,
  input logic                      ar_ready,
  input logic [xlen-1:0]           ar_addr,
  input logic [2:0]                ar_size,
  input logic                      aw_valid,
  input logic                      aw_ready,
  input logic [xlen-1:0]           aw_addr,
  input logic [2:0]                aw_size,
  input logic                      w_valid,
  input logic                      w_ready,
  input logic [bus_width-1:0]      w_data,
  input logic [bus_width/8-1:0]    w_strb,
  input logic                      b_valid,
  input logic                      b_ready,
  input logic                      r_valid,
  input logic                      r_ready
);
  timeunit 1ns;
  timeprecision 1ps;

  in_hold: assert property (@(posedge clock) disable iff (reset)
    in_valid && !in_ready |=> in_valid &&
      $stable({in_pc, in_val_a, in_val_b, in_val_c, in_alu_src, in_alu_op, in_alu_mod,
               in_rd, in_rd_src, in_ls, in_goto, in_csrw}))
    else $error("decode payload changed before in_ready");

  out_hold: assert property (@(posedge clock) disable iff (reset)
    out_valid && !out_ready |=> out_valid &&
      $stable({out_pc, out_gpr_wen, out_gpr_waddr, out_gpr_wdata, out_csr_wen,
               out_csr_waddr, out_csr_wdata, jump_en, jump_target}))
    else $error("writeback payload changed before out_ready");

  ar_hold: assert property (@(posedge clock) disable iff (reset)
    ar_valid && !ar_ready |=> ar_valid && $stable({ar_addr, ar_size}))
    else $error("read address dropped before ar_ready");

  aw_hold: assert property (@(posedge clock) disable iff (reset)
    aw_valid && !aw_ready |=> aw_valid && $stable({aw_addr, aw_size}))
    else $error("write address dropped before aw_ready");

  w_hold: assert property (@(posedge clock) disable iff (reset)
    w_valid && !w_ready |=> w_valid && $stable({w_data, w_strb}))
    else $error("write data dropped before w_ready");

  // the stage keeps waiting for a response once it has asked for one
  r_b_wait: assert property (@(posedge clock) disable iff (reset)
    (r_ready && !r_valid |=> r_ready) and (b_ready && !b_valid |=> b_ready))
    else $error("response ready dropped before valid");

  reset_quiet: assert property (@(posedge clock) reset |=> !out_valid)
    else $error("out_valid high during reset");

  stall_blocks: assert property (@(posedge clock) disable iff (reset)
    out_valid && !out_ready |-> !in_ready)
    else $error("in_ready high while result stalled");

endmodule

bind exec_stage exec_stage_checker #(.bus_width(bus_width)) handshake_checks (.*);

/* testbench/exec_stage_tb.sv */
module exec_stage_tb
  import exec_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int bus_width = 64;
  localparam int wait_limit = 200;

  typedef struct packed {
    logic [xlen-1:0]           pc;
    logic                      gpr_wen;
    logic [gpr_addr_width-1:0] gpr_waddr;
    logic [xlen-1:0]           gpr_wdata;
    logic                      csr_wen;
    logic [csr_addr_width-1:0] csr_waddr;
    logic [xlen-1:0]           csr_wdata;
    logic                      jump_en;
    logic [xlen-1:0]           jump_target;
    logic [xlen-1:0]           mem_addr;
    logic [2:0]                mem_size;
  } expect_t;

  logic clock, reset, in_valid, in_ready, in_alu_src, in_alu_mod, in_rd_src;
  logic [xlen-1:0] in_pc, in_val_a, in_val_b, in_val_c;
  alu_op_t in_alu_op;
  logic [gpr_addr_width-1:0] in_rd;
  ls_op_t in_ls;
  goto_op_t in_goto;
  csrw_op_t in_csrw;
  logic out_valid, out_ready, out_gpr_wen, out_csr_wen, jump_en;
  logic [xlen-1:0] out_pc, out_gpr_wdata, out_csr_wdata, jump_target;
  logic [gpr_addr_width-1:0] out_gpr_waddr;
  logic [csr_addr_width-1:0] out_csr_waddr;
  logic ar_valid, ar_ready, r_valid, r_ready, aw_valid, aw_ready;
  logic w_valid, w_ready, b_valid, b_ready;
  logic [xlen-1:0] ar_addr, aw_addr;
  logic [2:0] ar_size, aw_size;
  logic [bus_width-1:0] r_data, w_data;
  logic [bus_width/8-1:0] w_strb;

  logic [7:0]  shadow [0:255];
  logic [31:0] seed = 32'd69841;
  expect_t     expected[$];
  expect_t     in_flight;
  int          sent = 0;
  int          checked = 0;

  exec_stage #(.bus_width(bus_width)) uut (.*);
  axi_mem_model #(.bus_width(bus_width)) mem_model (.*);

  initial clock = 1'b0;
  always #50 clock = ~clock;

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return {seed[15:0], seed[31:16]};
  endfunction

  task automatic end_failed();
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic fail_value(input string msg);
    $display("FAIL at %0t ns: %s", $time, msg);
    end_failed();
  endtask

  task automatic fail_plain(input string msg);
    $display("%s", msg);
    end_failed();
  endtask

  function automatic logic [xlen-1:0] alu_model(input logic [xlen-1:0] a, b,
                                               input alu_op_t op, input logic mod);
    case (op)
      alu_add: return mod ? a - b : a + b;
      alu_sll: return a << b[4:0];
      alu_slt: return xlen'($signed(a) < $signed(b));
      alu_sltu: return xlen'(a < b);
      alu_xor: return a ^ b;
      alu_srl: return mod ? xlen'($signed(a) >>> b[4:0]) : a >> b[4:0];
      alu_or: return a | b;
      default: return a & b;
    endcase
  endfunction

  // applies the stage rules, and updates the shadow memory on stores
  function automatic expect_t predict(input logic [xlen-1:0] pc, a, b, c, input logic src,
                                      input alu_op_t op, input logic mod,
                                      input logic [gpr_addr_width-1:0] rd, input logic rd_src,
                                      input ls_op_t ls, input goto_op_t goto,
                                      input csrw_op_t csrw);
    expect_t e;
    logic [xlen-1:0] r, loaded;
    int n;
    r = alu_model(src ? pc : a, b, op, mod);
    n = (ls[1:0] == 2'd0) ? 1 : (ls[1:0] == 2'd1) ? 2 : 4;
    loaded = '0;
    for (int k = 0; k < n; k++) begin
      if (ls != ls_none && !ls[3]) shadow[8'(r + k)] = c[8*k +: 8];
      loaded[8*k +: 8] = shadow[8'(r + k)];
    end
    if (ls[2] && n == 1) loaded = {{24{loaded[7]}}, loaded[7:0]};
    if (ls[2] && n == 2) loaded = {{16{loaded[15]}}, loaded[15:0]};
    e.pc = pc;
    e.gpr_wen = rd != 0;
    e.gpr_waddr = rd;
    e.gpr_wdata = ls[3] ? loaded : (rd_src ? a : r);
    e.csr_wen = csrw != csrw_none;
    e.csr_waddr = (csrw == csrw_ebreak) ? '0 : c[csr_addr_width-1:0];
    e.csr_wdata = (csrw == csrw_write_alu) ? r : b;
    case (goto)
      goto_jal: e.jump_target = pc + c;
      goto_jalr: e.jump_target = a + c;
      default: e.jump_target = (goto == goto_trap_ret) ? a : pc + c;
    endcase
    e.jump_target[0] = 1'b0;
    e.jump_en = goto == goto_jal || goto == goto_jalr || goto == goto_trap_ret ||
                (goto == goto_branch_nz && r != 0) || (goto == goto_branch_z && r == 0);
    // bus size field is log2 of the byte count
    e.mem_addr = r;
    e.mem_size = (n == 1) ? 3'd0 : (n == 2) ? 3'd1 : 3'd2;
    return e;
  endfunction

  task automatic check_gpr(input logic wen, input logic [gpr_addr_width-1:0] waddr,
                           input logic [xlen-1:0] wdata, input expect_t e);
    if (wen !== e.gpr_wen || (wen && (waddr !== e.gpr_waddr || wdata !== e.gpr_wdata)))
      fail_value($sformatf("gpr write %0b x%0d=%h, expected %0b x%0d=%h",
                           wen, waddr, wdata, e.gpr_wen, e.gpr_waddr, e.gpr_wdata));
  endtask

  task automatic check_csr(input logic wen, input logic [csr_addr_width-1:0] waddr,
                           input logic [xlen-1:0] wdata, input expect_t e);
    if (wen !== e.csr_wen || (wen && (waddr !== e.csr_waddr || wdata !== e.csr_wdata)))
      fail_value($sformatf("csr write %0b %h=%h, expected %0b %h=%h",
                           wen, waddr, wdata, e.csr_wen, e.csr_waddr, e.csr_wdata));
  endtask

  task automatic check_jump(input logic en, input logic [xlen-1:0] target, input expect_t e);
    if (en !== e.jump_en || (en && target !== e.jump_target))
      fail_value($sformatf("jump %0b to %h, expected %0b to %h",
                           en, target, e.jump_en, e.jump_target));
  endtask

  task automatic check_request(input logic [xlen-1:0] addr, input logic [2:0] size,
                               input expect_t e);
    if (addr !== e.mem_addr || size !== e.mem_size)
      fail_value($sformatf("memory request %h size %0d, expected %h size %0d",
                           addr, size, e.mem_addr, e.mem_size));
  endtask

  always @(posedge clock) begin : compare_results
    expect_t e;
    if (!reset && out_valid && out_ready) begin
      if (expected.size() == 0) fail_plain("output transfer with no instruction outstanding");
      e = expected.pop_front();
      if (out_pc !== e.pc) fail_value($sformatf("out_pc %h, expected %h", out_pc, e.pc));
      check_gpr(out_gpr_wen, out_gpr_waddr, out_gpr_wdata, e);
      check_csr(out_csr_wen, out_csr_waddr, out_csr_wdata, e);
      check_jump(jump_en, jump_target, e);
      checked++;
    end
  end

  // address and size of each memory request
  always @(posedge clock) begin : compare_requests
    if (!reset && ar_valid && ar_ready) check_request(ar_addr, ar_size, in_flight);
    if (!reset && aw_valid && aw_ready) check_request(aw_addr, aw_size, in_flight);
  end

  // random writeback stalls
  always @(negedge clock) out_ready = next_rand() % 4 != 0;

  task automatic send(input logic [xlen-1:0] a, b, c, input logic src, input alu_op_t op,
                      input logic mod, input logic [gpr_addr_width-1:0] rd,
                      input logic rd_src, input ls_op_t ls, input goto_op_t goto,
                      input csrw_op_t csrw);
    int waited;
    logic was_idle;
    logic [xlen-1:0] pc;
    pc = next_rand() & 32'hffff_fffc;
    @(negedge clock);
    in_pc = pc;
    in_val_a = a;
    in_val_b = b;
    in_val_c = c;
    in_alu_src = src;
    in_alu_op = op;
    in_alu_mod = mod;
    in_rd = rd;
    in_rd_src = rd_src;
    in_ls = ls;
    in_goto = goto;
    in_csrw = csrw;
    in_valid = 1'b1;
    waited = 0;
    @(posedge clock);
    while (!in_ready) begin
      waited++;
      if (waited > wait_limit) fail_plain("timeout: decode handshake never saw in_ready");
      @(posedge clock);
    end
    was_idle = !out_valid;
    in_flight = predict(pc, a, b, c, src, op, mod, rd, rd_src, ls, goto, csrw);
    expected.push_back(in_flight);
    sent++;
    if (was_idle && ls == ls_none) begin
      @(negedge clock);
      in_valid = 1'b0;
      @(posedge clock);
      if (!out_valid) fail_value("out_valid not high one cycle after accept");
    end
  endtask

  task automatic send_mem(input ls_op_t ls, input logic [7:0] addr);
    logic [xlen-1:0] a;
    a = next_rand() % 200;
    send(a, xlen'(addr) - a, next_rand(), 1'b0, alu_add, 1'b0,
         ls[3] ? gpr_addr_width'(next_rand() % 31 + 1) : '0, 1'b0, ls, goto_none, csrw_none);
  endtask

  initial begin : stimulus
    ls_op_t stores[3];
    ls_op_t loads[5];
    logic [7:0] base;
    logic [xlen-1:0] a;
    int waited, step;
    stores = '{ls_sb, ls_sh, ls_sw};
    loads = '{ls_lb, ls_lbu, ls_lh, ls_lhu, ls_lw};
    {in_valid, in_pc, in_val_a, in_val_b, in_val_c, in_alu_src, in_alu_mod} = '0;
    {in_rd, in_rd_src} = '0;
    in_alu_op = alu_add;
    in_ls = ls_none;
    in_goto = goto_none;
    in_csrw = csrw_none;
    out_ready = 1'b0;
    for (int i = 0; i < 256; i++) begin
      shadow[i] = 8'(i * 29) ^ 8'(i >> 3) ^ 8'h5a;
      mem_model.mem[i] = shadow[i];
    end
    reset = 1'b1;
    repeat (3) @(posedge clock);
    @(negedge clock);
    if ({in_ready, out_valid, jump_en, ar_valid, r_ready, aw_valid, w_valid, b_ready} !== '0)
      fail_plain("handshake and jump outputs not low at the end of reset");
    reset = 1'b0;
    @(posedge clock);

    for (int i = 0; i < 40; i++)
      send(next_rand(), next_rand(), next_rand(), next_rand() % 2, alu_op_t'(next_rand() % 8),
           next_rand() % 2, next_rand() % 32, next_rand() % 4 == 0, ls_none, goto_none,
           csrw_none);

    // stores at every offset of one bus word, then loads of every kind
    for (int s = 0; s < 3; s++) begin
      base = next_rand() & 8'hf8;
      step = 1 << s;
      for (int off = 0; off < 8; off += step) send_mem(stores[s], base + 8'(off));
      for (int l = 0; l < 5; l++) begin
        step = 1 << loads[l][1:0];
        for (int off = 0; off < 8; off += step) send_mem(loads[l], base + 8'(off));
      end
    end

    for (int g = 1; g < 6; g++) begin
      for (int i = 0; i < 6; i++) begin
        a = next_rand();
        send(a, (next_rand() % 2) ? a : next_rand(), next_rand(), 1'b0, alu_xor, 1'b0,
             next_rand() % 32, 1'b0, ls_none, goto_op_t'(g), csrw_none);
      end
    end

    for (int c = 1; c < 4; c++) begin
      for (int i = 0; i < 5; i++)
        send(next_rand(), next_rand(), next_rand(), 1'b0, alu_op_t'(next_rand() % 8), 1'b0,
             next_rand() % 32, 1'b0, ls_none, goto_none, csrw_op_t'(c));
    end

    @(negedge clock);
    in_valid = 1'b0;
    waited = 0;
    while (checked != sent) begin
      waited++;
      if (waited > wait_limit) fail_plain("timeout: results still outstanding at writeback");
      @(posedge clock);
    end
    repeat (4) @(posedge clock);
    if (expected.size() != 0 || checked != sent) begin
      fail_plain("number of results does not match number of instructions sent");
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

/* sources.f */
rtl/exec_pkg.sv
rtl/alu.sv
rtl/branch_unit.sv
rtl/mem_align.sv
rtl/exec_control.sv
rtl/exec_stage.sv
testbench/axi_mem_model.sv
testbench/exec_stage_checker.sv
testbench/exec_stage_tb.sv
